/* src/exec_pkg.sv */
package exec_pkg;

    localparam int WORD_W   = 32;                     // Data path width
    localparam int OP_W     = 5;                      // Operation code width
    localparam int SHAMT_W  = 5;                      // Shift amount width
    localparam int MD_STEPS = 32;                     // Iterations per multiply or divide
    localparam int MD_CNT_W = $clog2(MD_STEPS);

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [SHAMT_W-1:0] shamt_t;
    typedef logic [OP_W-1:0]    alu_op_t;

    localparam alu_op_t OP_AND   = 5'd0;
    localparam alu_op_t OP_OR    = 5'd1;
    localparam alu_op_t OP_XOR   = 5'd2;
    localparam alu_op_t OP_ADDU  = 5'd3;
    localparam alu_op_t OP_SUBU  = 5'd4;
    localparam alu_op_t OP_SLTU  = 5'd5;
    localparam alu_op_t OP_SLT   = 5'd6;
    localparam alu_op_t OP_MULTU = 5'd7;
    localparam alu_op_t OP_MULT  = 5'd8;
    localparam alu_op_t OP_SLL   = 5'd9;
    localparam alu_op_t OP_SLLV  = 5'd10;
    localparam alu_op_t OP_SRA   = 5'd11;
    localparam alu_op_t OP_SRL   = 5'd12;
    localparam alu_op_t OP_SRAV  = 5'd13;
    localparam alu_op_t OP_SRLV  = 5'd14;
    localparam alu_op_t OP_DIV   = 5'd15;
    localparam alu_op_t OP_DIVU  = 5'd16;
    localparam alu_op_t OP_MFHI  = 5'd17;              // Read HI
    localparam alu_op_t OP_MFLO  = 5'd18;              // Read LO
    localparam alu_op_t OP_BLTZ  = 5'd19;
    localparam alu_op_t OP_BGTZ  = 5'd20;
    localparam alu_op_t OP_BGEZ  = 5'd21;
    localparam alu_op_t OP_BNE   = 5'd22;
    localparam alu_op_t OP_BLEZ  = 5'd23;
    localparam alu_op_t OP_JR    = 5'd24;              // Jump target pass-through
    localparam alu_op_t OP_MTHI  = 5'd25;              // Write HI
    localparam alu_op_t OP_MTLO  = 5'd26;              // Write LO

    // Iterative multiply/divide sequencing
    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_FIX
    } md_state_t;

endpackage

/* src/alu.sv */
`timescale 1ns/1ns

module alu (
    input  exec_pkg::alu_op_t op,
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::word_t   hi,
    input  exec_pkg::word_t   lo,
    input  exec_pkg::shamt_t  shamt,
    output exec_pkg::word_t   y,
    output logic              zero
);
    import exec_pkg::*;

    shamt_t var_sh;                                   // Variable shift amount
    logic   a_neg;
    logic   a_is_zero;

    assign var_sh    = a[SHAMT_W-1:0];
    assign a_neg     = a[WORD_W-1];
    assign a_is_zero = (a == '0);

    always_comb begin
        case (op)
            OP_AND:  y = a & b;
            OP_OR:   y = a | b;
            OP_XOR:  y = a ^ b;
            OP_ADDU: y = a + b;
            OP_SUBU: y = a - b;
            OP_SLTU: y = word_t'(a < b);
            OP_SLT:  y = word_t'($signed(a) < $signed(b));

            OP_SLL:  y = b << shamt;
            OP_SLLV: y = b << var_sh;
            OP_SRL:  y = b >> shamt;
            OP_SRLV: y = b >> var_sh;
            OP_SRA:  y = word_t'($signed(b) >>> shamt);
            OP_SRAV: y = word_t'($signed(b) >>> var_sh);

            OP_MFHI: y = hi;
            OP_MFLO: y = lo;

            // Branch compares give 0 when taken
            OP_BLTZ: y = word_t'(!a_neg);
            OP_BGTZ: y = word_t'(!(!a_neg && !a_is_zero));
            OP_BGEZ: y = word_t'(a_neg);
            OP_BNE:  y = word_t'(a == b);
            OP_BLEZ: y = word_t'(!(a_neg || a_is_zero));

            OP_JR:   y = a;                           // Target address
            default: y = '0;                          // HI/LO ops have no result
        endcase
    end

    assign zero = (y == '0);

endmodule

/* src/muldiv_unit.sv */
`timescale 1ns/1ns

module muldiv_unit (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start,
    input  exec_pkg::alu_op_t op,
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    output logic              busy,
    output logic              done,
    output exec_pkg::word_t   hi_result,
    output exec_pkg::word_t   lo_result
);
    import exec_pkg::*;

    md_state_t             state;
    logic [MD_CNT_W-1:0]   step_cnt;
    logic [2*WORD_W-1:0]   acc;                       // Product, or remainder and quotient
    word_t                 md_b;                      // Multiplicand or divisor magnitude
    logic                  is_div;
    logic                  neg_lo;                    // Negate product or quotient
    logic                  neg_hi;                    // Remainder follows dividend sign
    logic                  div_zero;

    logic                  signed_op;
    logic                  a_neg;
    logic                  b_neg;
    word_t                 a_mag;
    word_t                 b_mag;
    logic [WORD_W:0]       mul_sum;
    logic [WORD_W:0]       div_shift;
    logic [WORD_W:0]       div_diff;
    logic                  div_fits;
    logic [2*WORD_W-1:0]   prod_fix;

    assign signed_op = (op == OP_MULT) || (op == OP_DIV);
    assign a_neg     = signed_op && a[WORD_W-1];
    assign b_neg     = signed_op && b[WORD_W-1];
    assign a_mag     = a_neg ? -a : a;
    assign b_mag     = b_neg ? -b : b;

    // Shift-add step
    assign mul_sum = {1'b0, acc[2*WORD_W-1:WORD_W]} + (acc[0] ? {1'b0, md_b} : '0);

    // Restoring divide step
    assign div_shift = {acc[2*WORD_W-1:WORD_W], acc[WORD_W-1]};
    assign div_fits  = (div_shift >= {1'b0, md_b});
    assign div_diff  = div_shift - {1'b0, md_b};

    assign prod_fix = neg_lo ? -acc : acc;
    assign busy     = (state != MD_IDLE);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= MD_IDLE;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                MD_IDLE: begin
                    if (start) begin
                        state    <= MD_RUN;
                        step_cnt <= '0;
                    end
                end
                MD_RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == MD_CNT_W'(MD_STEPS - 1)) begin
                        state <= MD_FIX;           // Last step done
                    end
                end
                MD_FIX: begin
                    state <= MD_IDLE;
                    done  <= 1'b1;
                end
                default: state <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MD_IDLE && start) begin
            is_div   <= (op == OP_DIV) || (op == OP_DIVU);
            neg_lo   <= a_neg ^ b_neg;
            neg_hi   <= a_neg;
            div_zero <= (b == '0);
            if ((op == OP_DIV) || (op == OP_DIVU)) begin
                acc  <= {{WORD_W{1'b0}}, a_mag};      // Dividend shifts out of the low half
                md_b <= b_mag;
            end else begin
                acc  <= {{WORD_W{1'b0}}, b_mag};      // Multiplier bits consumed from bit 0
                md_b <= a_mag;
            end
        end else if (state == MD_RUN) begin
            if (is_div) begin
                acc <= div_fits ? {div_diff[WORD_W-1:0], acc[WORD_W-2:0], 1'b1}
                                : {div_shift[WORD_W-1:0], acc[WORD_W-2:0], 1'b0};
            end else begin
                acc <= {mul_sum, acc[WORD_W-1:1]};
            end
        end else if (state == MD_FIX) begin
            if (is_div) begin
                lo_result <= div_zero ? '1 : (neg_lo ? -acc[WORD_W-1:0] : acc[WORD_W-1:0]);
                hi_result <= neg_hi ? -acc[2*WORD_W-1:WORD_W] : acc[2*WORD_W-1:WORD_W];
            end else begin
                hi_result <= prod_fix[2*WORD_W-1:WORD_W];
                lo_result <= prod_fix[WORD_W-1:0];
            end
        end
    end

    // The stage must hold off new work until the unit is free
    start_while_busy: assert property (@(posedge clk) disable iff (!reset_n)
        start |-> !busy);

endmodule

/* src/hilo_regs.sv */
`timescale 1ns/1ns

module hilo_regs (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            md_done,
    input  logic            wr_hi,
    input  logic            wr_lo,
    input  exec_pkg::word_t md_hi,
    input  exec_pkg::word_t md_lo,
    input  exec_pkg::word_t wdata,
    output exec_pkg::word_t hi,
    output exec_pkg::word_t lo
);
    import exec_pkg::*;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            hi <= '0;
            lo <= '0;
        end else if (md_done) begin
            hi <= md_hi;                              // Multiply/divide result
            lo <= md_lo;
        end else begin
            if (wr_hi) begin
                hi <= wdata;                          // MTHI
            end
            if (wr_lo) begin
                lo <= wdata;                          // MTLO
            end
        end
    end

    // Writes from the stage are blocked while a result is landing
    done_vs_write: assert property (@(posedge clk) disable iff (!reset_n)
        md_done |-> !(wr_hi || wr_lo));

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  exec_pkg::alu_op_t op,
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::shamt_t  shamt,
    output logic              out_valid,
    input  logic              out_ready,
    output exec_pkg::word_t   y,
    output logic              zero
);
    import exec_pkg::*;

    word_t alu_y;
    logic  alu_zero;
    word_t hi;
    word_t lo;
    logic  md_busy;
    logic  md_done;
    word_t md_hi;
    word_t md_lo;

    logic  accept;
    logic  is_md;
    logic  is_mthi;
    logic  is_mtlo;
    logic  is_single;                                 // Produces an output beat
    logic  md_start;
    logic  wr_hi;
    logic  wr_lo;

    assign is_md     = (op == OP_MULT) || (op == OP_MULTU) || (op == OP_DIV) || (op == OP_DIVU);
    assign is_mthi   = (op == OP_MTHI);
    assign is_mtlo   = (op == OP_MTLO);
    assign is_single = !(is_md || is_mthi || is_mtlo);

    // Done also blocks so a following MFHI sees the new HI
    assign in_ready = !md_busy && !md_done && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    assign md_start = accept && is_md;
    assign wr_hi    = accept && is_mthi;
    assign wr_lo    = accept && is_mtlo;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (accept && is_single) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;                        // Drained
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_single) begin
            y    <= alu_y;
            zero <= alu_zero;
        end
    end

    alu u_alu (
        .op    (op),
        .a     (a),
        .b     (b),
        .hi    (hi),
        .lo    (lo),
        .shamt (shamt),
        .y     (alu_y),
        .zero  (alu_zero)
    );

    muldiv_unit u_muldiv_unit (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (md_start),
        .op        (op),
        .a         (a),
        .b         (b),
        .busy      (md_busy),
        .done      (md_done),
        .hi_result (md_hi),
        .lo_result (md_lo)
    );

    hilo_regs u_hilo_regs (
        .clk     (clk),
        .reset_n (reset_n),
        .md_done (md_done),
        .wr_hi   (wr_hi),
        .wr_lo   (wr_lo),
        .md_hi   (md_hi),
        .md_lo   (md_lo),
        .wdata   (a),
        .hi      (hi),
        .lo      (lo)
    );

    // Stalled result holds until taken
    out_hold: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(y) && $stable(zero));

endmodule

/* tb/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Shadow copies of the architectural HI and LO
word_t shadow_hi = '0;
word_t shadow_lo = '0;

function automatic word_t flag_word(input logic cond);
    return cond ? 32'd1 : 32'd0;
endfunction

function automatic word_t expected_result(input alu_op_t o, input word_t x, input word_t z,
                                          input shamt_t s);
    int sx;
    int sz;
    sx = $signed(x);
    sz = $signed(z);
    case (o)
        OP_AND:  return x & z;
        OP_OR:   return x | z;
        OP_XOR:  return x ^ z;
        OP_ADDU: return x + z;
        OP_SUBU: return x - z;
        OP_SLTU: return flag_word(x < z);
        OP_SLT:  return flag_word(sx < sz);
        OP_SLL:  return z << s;
        OP_SRL:  return z >> s;
        OP_SRA:  return sz >>> s;
        OP_SLLV: return z << x[4:0];                 // Low five bits of a only
        OP_SRLV: return z >> x[4:0];
        OP_SRAV: return sz >>> x[4:0];
        OP_MFHI: return shadow_hi;
        OP_MFLO: return shadow_lo;
        OP_BLTZ: return flag_word(!(sx < 0));        // Taken branch reads 0
        OP_BGTZ: return flag_word(!(sx > 0));
        OP_BGEZ: return flag_word(!(sx >= 0));
        OP_BNE:  return flag_word(!(x != z));
        OP_BLEZ: return flag_word(!(sx <= 0));
        OP_JR:   return x;
        default: return '0;
    endcase
endfunction

task automatic update_hilo(input alu_op_t o, input word_t x, input word_t z);
    longint      sx;
    longint      sz;
    logic [63:0] prod;
    sx = $signed(x);
    sz = $signed(z);
    case (o)
        OP_MULT: begin
            prod = sx * sz;
            {shadow_hi, shadow_lo} = prod;
        end
        OP_MULTU: begin
            prod = {32'd0, x} * {32'd0, z};
            {shadow_hi, shadow_lo} = prod;
        end
        OP_DIV, OP_DIVU: begin
            if (z == '0) begin
                shadow_lo = '1;                      // Divide by zero
                shadow_hi = x;
            end else if (o == OP_DIV) begin
                shadow_lo = word_t'(sx / sz);        // Truncates toward zero
                shadow_hi = word_t'(sx % sz);
            end else begin
                shadow_lo = x / z;
                shadow_hi = x % z;
            end
        end
        OP_MTHI: shadow_hi = x;
        OP_MTLO: shadow_lo = x;
        default: ;
    endcase
endtask

`endif

/* tb/execute_stage_tb.sv */
`timescale 1ns/1ns

module execute_stage_tb;
    import exec_pkg::*;

    `include "exec_model.svh"

    localparam int TIMEOUT = 200;                     // Cycles allowed per wait

    logic    clk;
    logic    reset_n;
    logic    in_valid;
    logic    in_ready;
    alu_op_t op;
    word_t   a;
    word_t   b;
    shamt_t  shamt;
    logic    out_valid;
    logic    out_ready;
    word_t   y;
    logic    zero;

    integer  seed      = 32'h1f07_71f1;
    integer  rdy_seed  = 32'h1f07_71f1;
    int      errors    = 0;
    logic    timed_out = 1'b0;
    logic    stall_en  = 1'b0;
    word_t   exp_q[$];
    word_t   exp_y     = '0;
    logic    exp_any   = 1'b0;
    int      md_left   = 0;                           // Edges until HI/LO settle

    word_t   edge_vals[5]  = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    alu_op_t arith_ops[7]  = '{OP_AND, OP_OR, OP_XOR, OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU};
    alu_op_t branch_ops[6] = '{OP_BLTZ, OP_BGTZ, OP_BGEZ, OP_BNE, OP_BLEZ, OP_JR};
    alu_op_t md_ops[4]     = '{OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    word_t   md_a[8] = '{32'd7, -32'd7, 32'd7, -32'd7, 32'h8000_0000, 32'd100, -32'd100, 32'd0};
    word_t   md_b[8] = '{32'd2, 32'd2, -32'd2, -32'd2, -32'd1, 32'd0, 32'd0, 32'd5};
    shamt_t  shift_amts[4] = '{5'd0, 5'd1, 5'd16, 5'd31};

    execute_stage u_execute_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .a         (a),
        .b         (b),
        .shamt     (shamt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .y         (y),
        .zero      (zero)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (stall_en) begin
            out_ready <= ($random(rdy_seed) & 3) != 0;   // Low about a quarter of the time
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Scoreboard bookkeeping on every transfer
    always @(posedge clk) begin
        if (reset_n) begin
            if (md_left > 0) begin
                md_left = md_left - 1;
            end
            if (out_valid && out_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (in_valid && in_ready) begin
                if (op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU}) begin
                    update_hilo(op, a, b);
                    md_left = 34;                        // 32 steps, fix, done
                end else if (op == OP_MTHI || op == OP_MTLO) begin
                    update_hilo(op, a, b);
                end else begin
                    exp_q.push_back(expected_result(op, a, b, shamt));
                end
            end
            exp_any = (exp_q.size() > 0);
            exp_y   = exp_any ? exp_q[0] : '0;
        end
    end

    unexpected_beat: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && out_ready |-> exp_any)
        else begin
            errors++;
            $display("Output beat at %0t arrived with no expected result", $time);
        end

    y_check: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && out_ready && exp_any |-> y == exp_y)
        else begin
            errors++;
            $display("[FAIL] %0t y got %h expected %h", $time, $sampled(y), $sampled(exp_y));
        end

    zero_check: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && out_ready && exp_any |-> zero == (exp_y == '0))
        else begin
            errors++;
            $display("[FAIL] %0t zero got %b expected %b", $time, $sampled(zero),
                     $sampled(exp_y) == '0);
        end

    stall_check: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> $stable(y) && $stable(zero))
        else begin
            errors++;
            $display("Output changed while stalled at %0t", $time);
        end

    md_ready_check: assert property (@(posedge clk) disable iff (!reset_n)
        md_left > 0 |-> !in_ready)
        else begin
            errors++;
            $display("in_ready went high during a multiply or divide at %0t", $time);
        end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    task automatic issue_op(input alu_op_t o, input word_t x, input word_t z, input shamt_t s);
        int waited;
        waited = 0;
        if (timed_out) begin
            return;                                      // Stop feeding a hung DUT
        end
        in_valid <= 1'b1;
        op       <= o;
        a        <= x;
        b        <= z;
        shamt    <= s;
        @(posedge clk);
        while (!in_ready && waited < TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        in_valid <= 1'b0;
        if (waited >= TIMEOUT) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout at %0t waiting for in_ready", $time);
        end
    endtask

    task automatic issue_then_read(input alu_op_t o, input word_t x, input word_t z);
        issue_op(o, x, z, '0);
        issue_op(OP_MFHI, '0, '0, '0);
        issue_op(OP_MFLO, '0, '0, '0);
    endtask

    initial begin
        word_t  x;
        shamt_t amt;
        int     waited;
        in_valid  = 1'b0;
        op        = OP_AND;
        a         = '0;
        b         = '0;
        shamt     = '0;
        out_ready = 1'b1;
        reset_n   = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        foreach (arith_ops[i]) begin
            foreach (edge_vals[j]) begin
                foreach (edge_vals[k]) begin
                    issue_op(arith_ops[i], edge_vals[j], edge_vals[k], '0);
                end
            end
            repeat (20) issue_op(arith_ops[i], rand_word(), rand_word(), '0);
        end

        // Fixed amounts first, then random ones
        for (int i = 0; i < 12; i++) begin
            amt = (i < 4) ? shift_amts[i] : shamt_t'(rand_word());
            x   = rand_word();
            issue_op(OP_SLL, rand_word(), x, amt);
            issue_op(OP_SRL, rand_word(), x, amt);
            issue_op(OP_SRA, rand_word(), x | 32'h8000_0000, amt);
            issue_op(OP_SRA, rand_word(), x & 32'h7fff_ffff, amt);
            issue_op(OP_SLLV, (rand_word() & ~32'h1f) | amt, x, shamt_t'(rand_word()));
            issue_op(OP_SRLV, (rand_word() & ~32'h1f) | amt, x, shamt_t'(rand_word()));
            issue_op(OP_SRAV, (rand_word() & ~32'h1f) | amt, x | 32'h8000_0000, '0);
        end

        foreach (branch_ops[i]) begin
            foreach (edge_vals[j]) begin
                foreach (edge_vals[k]) begin
                    issue_op(branch_ops[i], edge_vals[j], edge_vals[k], '0);
                end
            end
            repeat (5) issue_op(branch_ops[i], rand_word(), rand_word(), '0);
        end

        foreach (md_ops[i]) begin
            foreach (md_a[j]) begin
                issue_then_read(md_ops[i], md_a[j], md_b[j]);
            end
            repeat (4) issue_then_read(md_ops[i], rand_word(), rand_word());
        end

        x = rand_word();
        issue_op(OP_MTHI, x, '0, '0);
        issue_op(OP_MTLO, ~x, '0, '0);
        issue_op(OP_MFHI, '0, '0, '0);
        issue_op(OP_MFLO, '0, '0, '0);
        issue_then_read(OP_MULT, rand_word(), rand_word());

        // Mixed traffic under back-pressure
        stall_en <= 1'b1;
        repeat (300) begin
            x = $unsigned($random(seed)) % 27;
            issue_op(alu_op_t'(x), rand_word(), rand_word(), shamt_t'(rand_word()));
        end
        stall_en <= 1'b0;

        waited = 0;
        @(negedge clk);
        while ((exp_q.size() != 0 || md_left != 0) && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (exp_q.size() != 0 || md_left != 0) begin
            errors++;
            $display("Timeout at %0t with %0d results never delivered", $time, exp_q.size());
        end

        $display("Checks complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* execute_stage.f */
+incdir+tb
src/exec_pkg.sv
src/alu.sv
src/muldiv_unit.sv
src/hilo_regs.sv
src/execute_stage.sv
tb/execute_stage_tb.sv

/* Bender.yml */
package:
  name: execute_stage

sources:
  - src/exec_pkg.sv
  - src/alu.sv
  - src/muldiv_unit.sv
  - src/hilo_regs.sv
  - src/execute_stage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/execute_stage_tb.sv
